/* Makefile */
# Verilator flow for the MDIO management controller
TOP = tb_mdio_mgmt

.PHONY: all lint clean

# Build, run, and pass only if the pass message shows up in the output
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /\*\*\* TEST PASSED \*\*\*/ { ok = 1 } END { exit !ok }'

obj_dir/V$(TOP): vlog.f rtl/*.sv tb/*.sv
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* rtl/mdio_cmd_decode.sv */
// Accepts one command per four-phase handshake; word must be stable while cmd_req is high
`timescale 1ns/1ps

module mdio_cmd_decode import mdio_pkg::*; (
    input  logic       RxClk,
    input  logic       rst,
    input  logic       cmd_req,
    input  mdio_cmd_t  cmd_word,
    mdio_cmd_if.decode cmd_if,
    mdio_res_if.decode res_if
);

    logic hold;     // Handshake open, ignore req until ack has dropped
    logic cmd_ok;   // ST and OP are legal
    logic accept;   // Take the word this cycle

    // ------------------------------------------------------------
    // Command check
    // ------------------------------------------------------------
    // Only the clause-22 start and the two defined opcodes pass
    assign cmd_ok = (cmd_word.st == ST_CODE) &&
                    ((cmd_word.op == OP_WRITE) || (cmd_word.op == OP_READ));

    // Req first seen high after the last handshake closed
    // Hold turns the req level into a rising-edge detect
    assign accept = cmd_req && !hold && !cmd_if.busy;

    // ------------------------------------------------------------
    // Launch or reject
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst) begin
            hold          <= 1'b0;
            cmd_if.start  <= 1'b0;
            res_if.reject <= 1'b0;
        end else begin
            cmd_if.start  <= accept && cmd_ok;    // One cycle after req seen
            res_if.reject <= accept && !cmd_ok;   // Same slot for a bad word

            if (accept) begin
                hold <= 1'b1;
            end else if (res_if.ack_low) begin
                hold <= 1'b0;                     // Ack fell, ready for the next req
            end
        end
    end

    // Command copy for the engine, stays put until the next accept
    always_ff @(posedge RxClk) begin
        if (accept) begin
            cmd_if.cmd <= cmd_word;
        end
    end

endmodule

/* rtl/mdio_frame_engine.sv */
// MDC_HALF must be 2 or more; one frame is 64 MDC periods, 128*MDC_HALF RxClk cycles
`timescale 1ns/1ps

module mdio_frame_engine import mdio_pkg::*; #(
    parameter int MDC_HALF = 4                     // RxClk cycles per MDC half period
) (
    input  logic       RxClk,
    input  logic       rst,
    mdio_cmd_if.engine cmd_if,
    mdio_res_if.engine res_if,
    output logic       mdc,
    output logic       mdio_o,
    output logic       mdio_oe,
    input  logic       mdio_i
);

    localparam int DIV_W = $clog2(2 * MDC_HALF);
    localparam int BIT_W = $clog2(PREAMBLE_BITS + FRAME_BITS);

    // Positions inside one bit period
    localparam logic [DIV_W-1:0] RISE_AT = DIV_W'(MDC_HALF - 1);       // MDC goes high next
    localparam logic [DIV_W-1:0] SMP_AT  = DIV_W'(MDC_HALF - 2);       // Strobe one cycle ahead
    localparam logic [DIV_W-1:0] LAST_AT = DIV_W'(2 * MDC_HALF - 1);   // MDC falls, next bit

    // Bit numbers counted from the first preamble bit
    localparam logic [BIT_W-1:0] FRAME_START = BIT_W'(PREAMBLE_BITS);
    localparam logic [BIT_W-1:0] TA_START    = BIT_W'(PREAMBLE_BITS + READ_ADDR_BITS);
    localparam logic [BIT_W-1:0] DATA_START  = BIT_W'(PREAMBLE_BITS + READ_ADDR_BITS + TA_BITS);
    localparam logic [BIT_W-1:0] LAST_BIT    = BIT_W'(PREAMBLE_BITS + FRAME_BITS - 1);

    phase_t                phase;
    logic [DIV_W-1:0]      div_cnt;    // Position within the bit period
    logic [BIT_W-1:0]      bit_cnt;    // Current bit, 0..63
    logic [BIT_W-1:0]      next_bit;
    logic [FRAME_BITS-1:0] frame_sr;   // Frame word, MSB is the next bit out
    logic                  bit_end;    // Last cycle of a bit period

    assign next_bit    = bit_cnt + 1'b1;
    assign bit_end     = (phase != PH_IDLE) && (div_cnt == LAST_AT);
    assign cmd_if.busy = (phase != PH_IDLE);

    // ------------------------------------------------------------
    // Divider, bit sequencer and pin drive
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst) begin
            phase          <= PH_IDLE;
            div_cnt        <= '0;
            bit_cnt        <= '0;
            mdc            <= 1'b0;
            mdio_o         <= 1'b1;
            mdio_oe        <= 1'b0;
            res_if.sample  <= 1'b0;
            res_if.done    <= 1'b0;
            res_if.is_read <= 1'b0;
        end else begin
            res_if.sample <= 1'b0;
            res_if.done   <= 1'b0;

            if (phase == PH_IDLE) begin
                div_cnt <= '0;
                bit_cnt <= '0;
                if (cmd_if.start) begin
                    phase          <= PH_PREAMBLE;
                    mdio_oe        <= 1'b1;          // First preamble bit, MDC still low
                    mdio_o         <= 1'b1;
                    res_if.is_read <= (cmd_if.cmd.op == OP_READ);
                end
            end else begin
                div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
                if (div_cnt == RISE_AT) mdc <= 1'b1;

                // Read data strobe lands one cycle before the rising MDC
                if (phase == PH_DATA && res_if.is_read && div_cnt == SMP_AT) begin
                    res_if.sample <= 1'b1;
                end

                if (bit_end) begin
                    mdc <= 1'b0;                    // New bit goes out with the falling MDC
                    if (bit_cnt == LAST_BIT) begin
                        phase       <= PH_IDLE;
                        res_if.done <= 1'b1;
                        mdio_oe     <= 1'b0;        // Back to the pull-up
                        mdio_o      <= 1'b1;
                    end else begin
                        bit_cnt <= next_bit;
                        if (next_bit == FRAME_START) phase <= PH_ADDR;
                        if (next_bit == TA_START)    phase <= PH_TA;
                        if (next_bit == DATA_START)  phase <= PH_DATA;

                        if (next_bit >= FRAME_START) begin
                            if (res_if.is_read && next_bit >= TA_START) begin
                                mdio_oe <= 1'b0;    // PHY owns TA and DATA on reads
                                mdio_o  <= 1'b1;
                            end else begin
                                mdio_o <= frame_sr[FRAME_BITS-1];
                            end
                        end
                    end
                end
            end
        end
    end

    // Frame shifter and read sampling
    always_ff @(posedge RxClk) begin
        if (phase == PH_IDLE && cmd_if.start) begin
            frame_sr <= cmd_if.cmd;
        end else if (bit_end && next_bit >= FRAME_START) begin
            frame_sr <= {frame_sr[FRAME_BITS-2:0], 1'b0};
        end

        if (phase == PH_DATA && div_cnt == SMP_AT) begin
            res_if.sample_bit <= mdio_i;            // Qualified by sample downstream
        end
    end

endmodule

/* rtl/mdio_if.sv */
// Single RxClk domain; start, reject, sample, done and ack_low are one-cycle pulses
`timescale 1ns/1ps

// Decode to frame engine
interface mdio_cmd_if import mdio_pkg::*; ();
    logic      start;   // Launch one frame, only while busy is low
    mdio_cmd_t cmd;     // Held stable for the whole frame
    logic      busy;    // Engine is outside PH_IDLE

    modport decode (output start, output cmd, input busy);
    modport engine (input start, input cmd, output busy);
endinterface

// ------------------------------------------------------------
// Frame engine and decode to result stage
// ------------------------------------------------------------
interface mdio_res_if ();
    logic sample;       // Read data bit is valid on sample_bit
    logic sample_bit;   // Registered mdio_i
    logic done;         // Frame finished
    logic is_read;      // Opcode of the frame in flight or last finished
    logic reject;       // Bad ST or OP, no frame sent
    logic ack_low;      // Handshake closed, ack just dropped

    modport engine (output sample, output sample_bit, output done, output is_read);

    modport capture (
        input  sample,
        input  sample_bit,
        input  done,
        input  is_read,
        input  reject,
        output ack_low
    );

    modport decode (output reject, input ack_low);
endinterface

/* rtl/mdio_mgmt_top.sv */
// Pad logic is external: mdio_o/mdio_oe drive the pin, mdio_i needs a pull-up when released
`timescale 1ns/1ps

// Latency: host raises cmd_req at edge N, cmd_ack is high after edge N + 128*MDC_HALF + 3
// A bad ST or OP gives cmd_ack after edge N + 2 with cmd_err set and no MDC activity
module mdio_mgmt_top import mdio_pkg::*; #(
    parameter int MDC_HALF = 4                  // MDC period is 2*MDC_HALF RxClk cycles
) (
    input  logic                  RxClk,
    input  logic                  rst,
    // Host command handshake
    input  logic                  cmd_req,
    input  logic [FRAME_BITS-1:0] cmd_word,     // ST, OP, PHYAD, REGAD, TA, DATA
    output logic                  cmd_ack,
    output logic [DATA_BITS-1:0]  rd_data,
    output logic                  cmd_err,
    // Management pins
    output logic                  mdc,
    output logic                  mdio_o,
    output logic                  mdio_oe,
    input  logic                  mdio_i
);

    // ------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------
    mdio_cmd_if cmd_if ();
    mdio_res_if res_if ();

    mdio_cmd_decode i_cmd_decode (
        .RxClk    (RxClk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd_word (cmd_word),
        .cmd_if   (cmd_if.decode),
        .res_if   (res_if.decode)
    );

    mdio_frame_engine #(.MDC_HALF(MDC_HALF)) i_frame_engine (
        .RxClk   (RxClk),
        .rst     (rst),
        .cmd_if  (cmd_if.engine),
        .res_if  (res_if.engine),
        .mdc     (mdc),
        .mdio_o  (mdio_o),
        .mdio_oe (mdio_oe),
        .mdio_i  (mdio_i)
    );

    mdio_read_capture i_read_capture (
        .RxClk   (RxClk),
        .rst     (rst),
        .res_if  (res_if.capture),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .rd_data (rd_data),
        .cmd_err (cmd_err)
    );

endmodule

/* rtl/mdio_pkg.sv */
// Clause-22 frames only; field widths must add up to the 32-bit command word
package mdio_pkg;

    // ------------------------------------------------------------
    // Start and opcode values
    // ------------------------------------------------------------
    localparam logic [1:0] ST_CODE  = 2'b01;   // Clause-22 start pattern
    localparam logic [1:0] OP_WRITE = 2'b01;
    localparam logic [1:0] OP_READ  = 2'b10;

    // ------------------------------------------------------------
    // Frame geometry
    // ------------------------------------------------------------
    localparam int PREAMBLE_BITS  = 32;        // All ones before ST
    localparam int FRAME_BITS     = 32;        // ST through DATA
    localparam int READ_ADDR_BITS = 14;        // ST + OP + PHYAD + REGAD
    localparam int PHYAD_BITS     = 5;
    localparam int REGAD_BITS     = 5;
    localparam int TA_BITS        = 2;
    localparam int DATA_BITS      = 16;

    // Engine position within a frame
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PREAMBLE,
        PH_ADDR,     // ST, OP, PHYAD, REGAD
        PH_TA,
        PH_DATA
    } phase_t;

    // Command word, MSB goes out first
    typedef struct packed {
        logic [1:0]            st;
        logic [1:0]            op;
        logic [PHYAD_BITS-1:0] phyad;
        logic [REGAD_BITS-1:0] regad;
        logic [TA_BITS-1:0]    ta;     // Sent as is on writes, ignored on reads
        logic [DATA_BITS-1:0]  data;
    } mdio_cmd_t;

endpackage

/* rtl/mdio_read_capture.sv */
// rd_data and cmd_err hold until the next accepted command; ack waits for req low to drop
`timescale 1ns/1ps

module mdio_read_capture import mdio_pkg::*; (
    input  logic                 RxClk,
    input  logic                 rst,
    mdio_res_if.capture          res_if,
    input  logic                 cmd_req,
    output logic                 cmd_ack,
    output logic [DATA_BITS-1:0] rd_data,
    output logic                 cmd_err
);

    logic [DATA_BITS-1:0] shift_q;   // Read bits, first one ends up as MSB

    // ------------------------------------------------------------
    // Handshake completion
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst) begin
            cmd_ack        <= 1'b0;
            cmd_err        <= 1'b0;
            res_if.ack_low <= 1'b0;
        end else begin
            res_if.ack_low <= 1'b0;
            if (res_if.done) begin
                cmd_ack <= 1'b1;            // One cycle after done
                cmd_err <= 1'b0;
            end else if (res_if.reject) begin
                cmd_ack <= 1'b1;
                cmd_err <= 1'b1;
            end else if (cmd_ack && !cmd_req) begin
                cmd_ack        <= 1'b0;
                res_if.ack_low <= 1'b1;     // Lets decode take the next req
            end
        end
    end

    // Read data path
    always_ff @(posedge RxClk) begin
        if (res_if.sample) begin
            shift_q <= {shift_q[DATA_BITS-2:0], res_if.sample_bit};
        end

        if (res_if.done) begin
            rd_data <= res_if.is_read ? shift_q : '0;   // Writes report zero
        end else if (res_if.reject) begin
            rd_data <= '0;
        end
    end

endmodule

/* tb/mdio_mgmt_chk.sv */
// Probes the engine phase and opcode through bind; all checks are off while rst is high
`timescale 1ns/1ps

module mdio_mgmt_chk import mdio_pkg::*; (
    input logic   RxClk,
    input logic   rst,
    input logic   cmd_req,
    input logic   cmd_ack,
    input logic   mdc,
    input logic   mdio_o,
    input logic   mdio_oe,
    input phase_t phase,      // Engine state
    input logic   is_read     // Opcode of the frame in flight
);

    // ------------------------------------------------------------
    // Handshake and pin protocol
    // ------------------------------------------------------------
    ack_needs_req: assert property (@(posedge RxClk) disable iff (rst)
        $rose(cmd_ack) |-> cmd_req)
        else $error("cmd_ack rose without cmd_req");

    // PHY owns the line for TA and DATA of a read
    released_on_read: assert property (@(posedge RxClk) disable iff (rst)
        (is_read && (phase == PH_TA || phase == PH_DATA)) |-> !mdio_oe)
        else $error("mdio_oe high during read turnaround or data");

    idle_mdc_low: assert property (@(posedge RxClk) disable iff (rst)
        (phase == PH_IDLE) |-> !mdc)
        else $error("mdc high while the engine is idle");

    // Data launched on the falling MDC only
    stable_while_high: assert property (@(posedge RxClk) disable iff (rst)
        $changed(mdio_o) |-> !mdc)
        else $error("mdio_o changed while mdc was high");

endmodule

bind mdio_mgmt_top mdio_mgmt_chk i_mdio_mgmt_chk (
    .RxClk   (RxClk),
    .rst     (rst),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .mdc     (mdc),
    .mdio_o  (mdio_o),
    .mdio_oe (mdio_oe),
    .phase   (i_frame_engine.phase),
    .is_read (res_if.is_read)
);

/* tb/phy_mdio_model.sv */
// Behavioral PHY at one address; needs 32 preamble ones before ST and ignores the TA field
`timescale 1ns/1ps

module phy_mdio_model import mdio_pkg::*; #(
    parameter logic [PHYAD_BITS-1:0] PHY_ADDR = 5'd1
) (
    input  logic mdc,
    input  logic mdio,         // Resolved line as the PHY sees it
    output logic drive_en,     // PHY owns the line
    output logic drive_val
);

    logic [DATA_BITS-1:0]  regs [32];
    logic [FRAME_BITS-1:0] rx_sr;      // Frame bits after the preamble
    logic [DATA_BITS-1:0]  tx_sr;      // Read data, MSB goes first
    logic [1:0]            op_q;
    logic [REGAD_BITS-1:0] reg_q;
    logic                  phy_hit;    // Frame is for this PHY
    logic                  talk;       // Addressed read in progress
    logic                  in_frame;
    int                    ones_cnt;   // Preamble ones seen
    int                    pos;        // Frame bits received so far

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = 16'(i * 16'h0911) ^ 16'hA53C;   // Power-up content
        end
        drive_en  = 1'b0;
        drive_val = 1'b1;
        in_frame  = 1'b0;
        talk      = 1'b0;
        ones_cnt  = 0;
        pos       = 0;
    end

    // ------------------------------------------------------------
    // Bit-serial frame decoder, one step per rising MDC
    // ------------------------------------------------------------
    always @(posedge mdc) begin
        if (!in_frame) begin
            if (mdio) begin
                ones_cnt = ones_cnt + 1;
            end else if (ones_cnt >= PREAMBLE_BITS) begin
                in_frame = 1'b1;                  // First ST bit, a zero
                rx_sr    = '0;
                pos      = 1;
            end else begin
                ones_cnt = 0;                     // Short preamble, start over
            end
        end else begin
            rx_sr = {rx_sr[FRAME_BITS-2:0], mdio};
            pos   = pos + 1;
            if (pos == READ_ADDR_BITS) begin
                op_q    = rx_sr[11:10];
                reg_q   = rx_sr[4:0];
                phy_hit = (rx_sr[9:5] == PHY_ADDR);
                talk    = phy_hit && (op_q == OP_READ);
                tx_sr   = regs[reg_q];
            end else if (talk && pos == READ_ADDR_BITS + 1) begin
                drive_en  = 1'b1;                 // Second TA bit low
                drive_val = 1'b0;
            end else if (talk && pos < FRAME_BITS) begin
                drive_val = tx_sr[DATA_BITS-1];   // Next data bit after this rise
                tx_sr     = {tx_sr[DATA_BITS-2:0], 1'b0};
            end else if (pos == FRAME_BITS) begin
                if (phy_hit && op_q == OP_WRITE) regs[reg_q] = rx_sr[DATA_BITS-1:0];
                drive_en  = 1'b0;                 // Back to the pull-up
                drive_val = 1'b1;
                talk      = 1'b0;
                in_frame  = 1'b0;
                ones_cnt  = 0;
            end
        end
    end

endmodule

/* tb/tb_mdio_mgmt.sv */
// MDC_HALF is 4; only PHY 1 answers, and all its registers are written before random use
`timescale 1ns/1ps

module tb_mdio_mgmt import mdio_pkg::*; ();

    localparam int MDC_HALF  = 4;
    localparam int TIMEOUT   = 2000;                 // Cycles per handshake wait
    localparam int FRAME_LAT = 128 * MDC_HALF + 3;   // Req seen to ack, valid command
    localparam int BAD_LAT   = 2;                    // Reject, then ack
    localparam int N_CMDS    = 400;

    logic                  RxClk;
    logic                  rst;
    logic                  cmd_req;
    logic [FRAME_BITS-1:0] cmd_word;
    logic                  cmd_ack;
    logic [DATA_BITS-1:0]  rd_data;
    logic                  cmd_err;
    logic                  mdc;
    logic                  mdio_o;
    logic                  mdio_oe;
    logic                  mdio_i;
    logic                  phy_en;
    logic                  phy_val;
    logic [DATA_BITS-1:0]  ref_regs [32];            // Expected content of PHY 1
    int                    seed           = 76482;
    int                    value_errors   = 0;
    int                    timeout_errors = 0;
    int                    mdc_rises      = 0;

    // PHY drive first, then the controller, else the pull-up
    assign mdio_i = phy_en ? phy_val : (mdio_oe ? mdio_o : 1'b1);

    initial RxClk = 1'b0;
    always #20 RxClk = ~RxClk;                       // 40 ns period
    always @(posedge mdc) mdc_rises++;

    mdio_mgmt_top #(.MDC_HALF(MDC_HALF)) i_mdio_mgmt_top (.*);

    phy_mdio_model #(.PHY_ADDR(5'd1)) i_phy (
        .mdc       (mdc),
        .mdio      (mdio_i),
        .drive_en  (phy_en),
        .drive_val (phy_val)
    );

    task automatic report_fail(input string what, input int got, input int exp);
        $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
        value_errors++;
    endtask

    // ------------------------------------------------------------
    // One four-phase handshake, checked against the reference
    // ------------------------------------------------------------
    task automatic run_command(input mdio_cmd_t c);
        logic                 valid;
        logic [DATA_BITS-1:0] exp_rd;
        int                   exp_lat;
        int                   cycles;
        int                   rises_at_req;
        valid   = (c.st == ST_CODE) && (c.op == OP_WRITE || c.op == OP_READ);
        exp_lat = valid ? FRAME_LAT : BAD_LAT;
        exp_rd  = '0;                                // Writes and rejects read back zero
        if (valid && c.op == OP_READ) exp_rd = (c.phyad == 5'd1) ? ref_regs[c.regad] : 16'hFFFF;
        @(posedge RxClk);
        cmd_req      <= 1'b1;
        cmd_word     <= c;
        rises_at_req = mdc_rises;
        @(negedge RxClk);
        cycles       = 0;                            // Edges since the req edge
        while (!cmd_ack && cycles < TIMEOUT) begin
            @(negedge RxClk);
            cycles++;
        end
        if (!cmd_ack) begin
            $display("Timeout: cmd_ack did not rise within %0d cycles", TIMEOUT);
            timeout_errors++;
            return;
        end
        assert (cmd_err == !valid) else report_fail("cmd_err", int'(cmd_err), int'(!valid));
        assert (rd_data == exp_rd) else report_fail("rd_data", int'(rd_data), int'(exp_rd));
        assert (cycles == exp_lat) else report_fail("req to ack cycles", cycles, exp_lat);
        if (!valid) begin
            assert (mdc_rises == rises_at_req)
                else report_fail("mdc rises on a rejected command", mdc_rises - rises_at_req, 0);
        end
        if (valid && c.op == OP_WRITE && c.phyad == 5'd1) ref_regs[c.regad] = c.data;
        @(posedge RxClk);
        cmd_req <= 1'b0;
        cycles  = 0;
        while (cmd_ack && cycles < TIMEOUT) begin
            @(negedge RxClk);
            cycles++;
        end
        if (cmd_ack) begin
            $display("Timeout: cmd_ack did not fall within %0d cycles", TIMEOUT);
            timeout_errors++;
        end
    endtask

    // Mostly PHY 1, about one command in ten with a bad ST or OP
    task automatic make_random(output mdio_cmd_t c);
        int roll;
        c.st    = ST_CODE;
        c.op    = ($random(seed) & 1) ? OP_READ : OP_WRITE;
        c.regad = 5'($random(seed));
        c.ta    = 2'b10;                             // Write turnaround
        c.data  = 16'($random(seed));
        c.phyad = 5'($random(seed));
        roll    = $unsigned($random(seed)) % 100;
        if (roll < 80) c.phyad = 5'd1;
        else if (c.phyad == 5'd1) c.phyad = 5'd0;    // Keep the absent case absent
        roll = $unsigned($random(seed)) % 100;
        if (roll < 5) c.st = ($random(seed) & 1) ? 2'b00 : 2'b11;
        else if (roll < 10) c.op = ($random(seed) & 1) ? 2'b00 : 2'b11;
    endtask

    // ------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------
    initial begin
        mdio_cmd_t c;
        rst      = 1'b1;
        cmd_req  = 1'b0;
        cmd_word = '0;
        repeat (2) @(posedge RxClk);
        rst <= 1'b0;
        @(negedge RxClk);
        assert ({cmd_ack, mdc, mdio_oe, mdio_o} == 4'b0001)
            else report_fail("ack, mdc, oe, mdio_o after reset",
                             int'({cmd_ack, mdc, mdio_oe, mdio_o}), 1);

        // Known content for every PHY 1 register
        for (int r = 0; r < 32 && timeout_errors == 0; r++) begin
            c = '{st: ST_CODE, op: OP_WRITE, phyad: 5'd1, regad: 5'(r), ta: 2'b10,
                  data: 16'($random(seed))};
            run_command(c);
        end
        c = '{st: ST_CODE, op: OP_WRITE, phyad: 5'd1, regad: 5'd7, ta: 2'b10, data: 16'hBEEF};
        run_command(c);
        c.op = OP_READ;                              // Same register back
        run_command(c);
        c.phyad = 5'd9;                              // Nobody home, pull-up answers
        run_command(c);
        c.st = 2'b11;                                // Bad start code
        run_command(c);

        for (int n = 0; n < N_CMDS && timeout_errors == 0; n++) begin
            make_random(c);
            run_command(c);
        end

        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/mdio_pkg.sv
rtl/mdio_if.sv
rtl/mdio_cmd_decode.sv
rtl/mdio_frame_engine.sv
rtl/mdio_read_capture.sv
rtl/mdio_mgmt_top.sv
tb/mdio_mgmt_chk.sv
tb/phy_mdio_model.sv
tb/tb_mdio_mgmt.sv
